//--- logic/carrierLoopPkg.sv
// Shared loop types and constants; the lag limit must stay below 2^31 and the table holds one quarter wave
package carrierLoopPkg;

  // -------------------
  // Widths
  localparam int errWidth    = 8;
  localparam int accWidth    = 40;
  localparam int freqWidth   = 32;
  localparam int sampleWidth = 18;
  localparam int tableBits   = 6;
  localparam int mixLatency  = 4;

  // Register map, byte addresses
  typedef enum logic [11:0] {
    ctrlReg     = 12'h000,
    gainReg     = 12'h004,
    limitReg    = 12'h008,
    lockReg     = 12'h00C,
    lagReadReg  = 12'h010,
    freqReadReg = 12'h014,
    statusReg   = 12'h018
  } regAddr_e;

  typedef struct packed {
    regAddr_e    addr;
    logic [31:0] data;
    logic [3:0]  byteWe;
  } regBus_t;

  typedef struct packed {
    logic        invertError;
    logic        zeroError;
    logic [4:0]  leadExp;
    logic [4:0]  lagExp;
    logic [31:0] limit;
    logic [15:0] lockCount;
    logic [7:0]  syncThreshold;
  } loopConfig_t;

  typedef enum logic {
    searching,
    locked
  } lockState_e;

  typedef struct packed {
    logic signed [sampleWidth-1:0] i;
    logic signed [sampleWidth-1:0] q;
  } iqSample_t;

  // -------------------
  // Quarter-wave sine, 131071 * sin(2*pi*k/256)
  localparam logic [sampleWidth-2:0] tablePeak = 131071;
  localparam logic [sampleWidth-2:0] sineTable [2**tableBits] = '{
    0, 3217, 6431, 9642, 12847, 16044, 19232, 22408,
    25571, 28718, 31848, 34958, 38048, 41115, 44156, 47172,
    50159, 53115, 56040, 58931, 61786, 64605, 67384, 70123,
    72819, 75472, 78079, 80639, 83151, 85612, 88022, 90379,
    92681, 94928, 97117, 99248, 101319, 103329, 105277, 107162,
    108982, 110736, 112423, 114043, 115594, 117076, 118487, 119826,
    121094, 122288, 123409, 124456, 125427, 126323, 127143, 127886,
    128553, 129141, 129652, 130085, 130440, 130716, 130913, 131032
  };

endpackage

//--- logic/loopRegs.sv
// Register bank; unmatched addresses read zero, read-only registers drop writes, clear bit self-clears
`timescale 1ns/1ps

module loopRegs import carrierLoopPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  regBus_t     bus,
  input  logic [31:0] lagAccum,
  input  logic [31:0] freqWord,
  input  lockState_e  lockState,
  output loopConfig_t cfg,
  output logic        clearAccum,
  output logic [31:0] readData
);

  logic [31:0] writeWord;

  // Replace only the enabled byte lanes
  function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [3:0]  laneWe);
    logic [31:0] merged;
    merged = oldWord;
    for (int lane = 0; lane < 4; lane++) begin
      if (laneWe[lane]) begin
        merged[lane*8 +: 8] = newWord[lane*8 +: 8];
      end
    end
    return merged;
  endfunction

  // Readback doubles as the current image of each writable register
  always_comb begin
    case (bus.addr)
      ctrlReg:     readData = {30'd0, cfg.zeroError, cfg.invertError};
      gainReg:     readData = {19'd0, cfg.lagExp, 3'd0, cfg.leadExp};
      limitReg:    readData = cfg.limit;
      lockReg:     readData = {8'd0, cfg.syncThreshold, cfg.lockCount};
      lagReadReg:  readData = lagAccum;
      freqReadReg: readData = freqWord;
      statusReg:   readData = {31'd0, lockState};
      default:     readData = '0;
    endcase
  end

  assign writeWord = mergeLanes(readData, bus.data, bus.byteWe);

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg        <= '0;
      clearAccum <= 1'b0;
    end else begin
      clearAccum <= 1'b0;
      if (|bus.byteWe) begin
        case (bus.addr)
          ctrlReg: begin
            cfg.invertError <= writeWord[0];
            cfg.zeroError   <= writeWord[1];
            clearAccum      <= bus.byteWe[0] & bus.data[2];
          end
          gainReg: begin
            cfg.leadExp <= writeWord[4:0];
            cfg.lagExp  <= writeWord[12:8];
          end
          limitReg: cfg.limit <= writeWord;
          lockReg: begin
            cfg.lockCount     <= writeWord[15:0];
            cfg.syncThreshold <= writeWord[23:16];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- logic/loopFilter.sv
// Lead/lag filter; gains are powers of two, limit is a positive magnitude on the upper 32 bits
`timescale 1ns/1ps

module loopFilter import carrierLoopPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 symEn,
  input  logic [errWidth-1:0]  phaseError,
  input  loopConfig_t          cfg,
  input  logic                 clearAccum,
  output logic [freqWidth-1:0] lagAccum,
  output logic [freqWidth-1:0] freqWord
);

  logic [errWidth-1:0]        adjError;
  logic signed [errWidth-1:0] loopError;
  logic signed [accWidth-1:0] lagAcc;
  logic signed [accWidth-1:0] filterSum;
  logic signed [accWidth-1:0] lagNext;
  logic signed [accWidth:0]   lagScaled;
  logic signed [accWidth:0]   leadScaled;
  logic signed [accWidth:0]   lagSum;
  logic signed [accWidth:0]   posLimit;
  logic signed [accWidth:0]   negLimit;

  // --------------------
  // Error adjust
  always_comb begin
    if (cfg.zeroError) begin
      adjError = '0;
    end else if (cfg.invertError) begin
      adjError = ~phaseError + 1'b1;
    end else begin
      adjError = phaseError;
    end
  end

  // Power-of-two gains on the sign-extended error
  assign lagScaled  = (accWidth+1)'(loopError) <<< cfg.lagExp;
  assign leadScaled = (accWidth+1)'(loopError) <<< cfg.leadExp;

  // Limit sits on the upper 32 bits of the accumulator
  assign posLimit = {1'b0, cfg.limit, {(accWidth-freqWidth){1'b0}}};
  assign negLimit = -posLimit;
  assign lagSum   = (accWidth+1)'(lagAcc) + lagScaled;

  always_comb begin
    if (lagSum > posLimit) begin
      lagNext = posLimit[accWidth-1:0];
    end else if (lagSum < negLimit) begin
      lagNext = negLimit[accWidth-1:0];
    end else begin
      lagNext = lagSum[accWidth-1:0];
    end
  end

  // --------------------
  // Strobed updates; both paths see the previous loopError
  always_ff @(posedge clk) begin
    if (reset) begin
      loopError <= '0;
      lagAcc    <= '0;
      filterSum <= '0;
    end else begin
      if (symEn) begin
        loopError <= adjError;
        filterSum <= lagAcc + leadScaled[accWidth-1:0];
      end
      if (clearAccum) begin
        lagAcc <= '0;
      end else if (symEn) begin
        lagAcc <= lagNext;
      end
    end
  end

  assign lagAccum = lagAcc[accWidth-1 -: freqWidth];
  assign freqWord = filterSum[accWidth-1 -: freqWidth];

endmodule

//--- logic/lockDetector.sv
// Lock detector; state flips only when the up/down counter wraps, so lockCount sets the hysteresis
`timescale 1ns/1ps

module lockDetector import carrierLoopPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                symEn,
  input  logic [errWidth-1:0] phaseError,
  input  loopConfig_t         cfg,
  input  logic                clearAccum,
  output lockState_e          lockState
);

  logic [errWidth-1:0] absError;
  logic [15:0]         lockCounter;
  logic [16:0]         lockPlus;
  logic [16:0]         lockMinus;

  // Magnitude of the raw error, -128 reads as 128
  assign absError  = phaseError[errWidth-1] ? ~phaseError + 1'b1 : phaseError;
  assign lockPlus  = {1'b0, lockCounter} + 17'd1;
  assign lockMinus = {1'b0, lockCounter} - 17'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      lockCounter <= '0;
      lockState   <= searching;
    end else if (clearAccum) begin
      lockCounter <= cfg.lockCount;
    end else if (symEn) begin
      if (absError > cfg.syncThreshold) begin
        // Bad symbol
        if (lockMinus[16]) begin
          lockState   <= searching;
          lockCounter <= cfg.lockCount;
        end else begin
          lockCounter <= lockMinus[15:0];
        end
      end else if (lockPlus[16]) begin
        lockState   <= locked;
        lockCounter <= cfg.lockCount;
      end else begin
        lockCounter <= lockPlus[15:0];
      end
    end
  end

endmodule

//--- logic/carrierNco.sv
// Phase-accumulator NCO; 256 points per cycle from a quarter-wave table, outputs lag phase by one clock
`timescale 1ns/1ps

module carrierNco import carrierLoopPkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [freqWidth-1:0]          freqWord,
  output logic signed [sampleWidth-1:0] cosine,
  output logic signed [sampleWidth-1:0] sine
);

  logic [freqWidth-1:0]          freqReg;
  logic [freqWidth-1:0]          phase;
  logic [1:0]                    quadrant;
  logic [tableBits-1:0]          index;
  logic signed [sampleWidth-1:0] sinVal;
  logic signed [sampleWidth-1:0] cosVal;

  // Point 2**tableBits is the peak just past the table end
  function automatic logic [sampleWidth-2:0] quarterSine(input logic [tableBits:0] point);
    if (point[tableBits]) begin
      return tablePeak;
    end
    return sineTable[point[tableBits-1:0]];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      freqReg <= '0;
      phase   <= '0;
    end else begin
      freqReg <= freqWord;
      phase   <= phase + freqReg;
    end
  end

  assign quadrant = phase[freqWidth-1 -: 2];
  assign index    = phase[freqWidth-3 -: tableBits];
  assign sinVal   = {1'b0, quarterSine({1'b0, index})};
  assign cosVal   = {1'b0, quarterSine((tableBits+1)'(2**tableBits) - {1'b0, index})};

  // --------------------
  // Quadrant folding
  always_ff @(posedge clk) begin
    case (quadrant)
      2'd0: begin
        cosine <= cosVal;
        sine   <= sinVal;
      end
      2'd1: begin
        cosine <= -sinVal;
        sine   <= cosVal;
      end
      2'd2: begin
        cosine <= -cosVal;
        sine   <= -sinVal;
      end
      default: begin
        cosine <= sinVal;
        sine   <= -cosVal;
      end
    endcase
  end

endmodule

//--- logic/derotator.sv
// Complex derotator; input capture plus three multiplier stages, results scaled by 2^-17 and truncated
`timescale 1ns/1ps

module derotator import carrierLoopPkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          symEn,
  input  logic                          sym2xEn,
  input  iqSample_t                     iqIn,
  input  logic signed [sampleWidth-1:0] cosine,
  input  logic signed [sampleWidth-1:0] sine,
  output iqSample_t                     iqOut,
  output logic                          symEnDly,
  output logic                          sym2xEnDly
);

  iqSample_t                       iqReg;
  logic signed [sampleWidth-1:0]   cosReg, sinReg;
  logic signed [2*sampleWidth-1:0] iCos, qSin, qCos, iSin;
  logic signed [2*sampleWidth:0]   iSum, qSum;
  logic [mixLatency-1:0]           symSr, sym2xSr;

  // Multiply by the conjugate phasor
  always_ff @(posedge clk) begin
    iqReg  <= iqIn;
    cosReg <= cosine;
    sinReg <= sine;
    iCos   <= iqReg.i * cosReg;
    qSin   <= iqReg.q * sinReg;
    qCos   <= iqReg.q * cosReg;
    iSin   <= iqReg.i * sinReg;
    iSum   <= iCos + qSin;
    qSum   <= qCos - iSin;
    iqOut.i <= iSum[2*sampleWidth-2 : sampleWidth-1];
    iqOut.q <= qSum[2*sampleWidth-2 : sampleWidth-1];
  end

  // Strobes ride alongside the samples
  always_ff @(posedge clk) begin
    if (reset) begin
      symSr   <= '0;
      sym2xSr <= '0;
    end else begin
      symSr   <= {symSr[mixLatency-2:0], symEn};
      sym2xSr <= {sym2xSr[mixLatency-2:0], sym2xEn};
    end
  end

  assign symEnDly   = symSr[mixLatency-1];
  assign sym2xEnDly = sym2xSr[mixLatency-1];

endmodule

//--- logic/carrierLoop.sv
// Carrier recovery loop top; one phase error per symEn, no back-pressure, iqOut lags iqIn by four clocks
`timescale 1ns/1ps

module carrierLoop import carrierLoopPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                symEn,
  input  logic                sym2xEn,
  input  logic [errWidth-1:0] phaseError,
  input  iqSample_t           iqIn,
  input  regBus_t             bus,
  output logic [31:0]         readData,
  output iqSample_t           iqOut,
  output logic                symEnDly,
  output logic                sym2xEnDly,
  output lockState_e          lockState
);

  loopConfig_t                   cfg;
  logic                          clearAccum;
  logic [freqWidth-1:0]          lagAccum;
  logic [freqWidth-1:0]          freqWord;
  logic signed [sampleWidth-1:0] cosine;
  logic signed [sampleWidth-1:0] sine;

  // --------------------
  // Decode
  loopRegs regs (
    .clk(clk), .reset(reset), .bus(bus),
    .lagAccum(lagAccum), .freqWord(freqWord), .lockState(lockState),
    .cfg(cfg), .clearAccum(clearAccum), .readData(readData)
  );

  // Execute
  loopFilter filter (
    .clk(clk), .reset(reset), .symEn(symEn), .phaseError(phaseError),
    .cfg(cfg), .clearAccum(clearAccum), .lagAccum(lagAccum), .freqWord(freqWord)
  );

  lockDetector lockDet (
    .clk(clk), .reset(reset), .symEn(symEn), .phaseError(phaseError),
    .cfg(cfg), .clearAccum(clearAccum), .lockState(lockState)
  );

  // Result
  carrierNco nco (
    .clk(clk), .reset(reset), .freqWord(freqWord), .cosine(cosine), .sine(sine)
  );

  derotator mixer (
    .clk(clk), .reset(reset), .symEn(symEn), .sym2xEn(sym2xEn), .iqIn(iqIn),
    .cosine(cosine), .sine(sine), .iqOut(iqOut),
    .symEnDly(symEnDly), .sym2xEnDly(sym2xEnDly)
  );

endmodule

//--- tb/carrierLoop_checker.sv
// Assertions bound into the loop top; lagAccum and limit are taken from internal nets
`timescale 1ns/1ps

module carrierLoop_checker import carrierLoopPkg::*; (
  input logic        clk,
  input logic        reset,
  input logic        symEn,
  input logic        symEnDly,
  input lockState_e  lockState,
  input logic [31:0] lagAccum,
  input logic [31:0] limit
);

  int assertFails = 0;

  // Strobe delay matches the mixer latency
  assert property (@(posedge clk) disable iff (reset) symEnDly == $past(symEn, mixLatency))
    else begin
      $error("symEnDly is not symEn delayed by four cycles");
      assertFails++;
    end

  assert property (@(posedge clk) disable iff (reset) $changed(lockState) |-> $past(symEn))
    else begin
      $error("lockState changed without a symbol strobe");
      assertFails++;
    end

  // Lag magnitude stays inside the limit
  assert property (@(posedge clk) disable iff (reset)
      ($signed(lagAccum) <= $signed({1'b0, limit})) &&
      ($signed(lagAccum) >= -$signed({1'b0, limit})))
    else begin
      $error("lagAccum exceeds the configured limit");
      assertFails++;
    end

endmodule

bind carrierLoop carrierLoop_checker chk (
  .clk(clk), .reset(reset), .symEn(symEn), .symEnDly(symEnDly),
  .lockState(lockState), .lagAccum(lagAccum), .limit(cfg.limit)
);

//--- tb/carrierLoopTb.sv
// Row-table testbench for the loop top; expected values come from a model run while the table is built
`timescale 1ns/1ps

module carrierLoopTb import carrierLoopPkg::*;;

  typedef enum logic [1:0] {rowWrite, rowRead, rowStrobe, rowIq} rowKind_e;
  typedef struct packed {
    rowKind_e    kind;
    regBus_t     bus;
    logic [7:0]  err;
    iqSample_t   iq;
    logic [31:0] expWord;
    lockState_e  expLock;
    iqSample_t   expIq;
  } row_t;

  logic clk, reset, symEn, sym2xEn, symEnDly, sym2xEnDly;
  logic [errWidth-1:0] phaseError;
  iqSample_t iqIn, iqOut;
  regBus_t bus;
  logic [31:0] readData;
  lockState_e lockState;

  row_t rows[$];
  int mismatches = 0;
  int failures = 0;
  int cycles = 0;
  int cycleLimit = 100;
  logic [31:0] rng = 32'd42973;

  // Model state
  logic [31:0] ctrlImg, gainImg, limitImg, lockImg;
  logic [7:0] mErr;
  logic signed [63:0] mLag, mSum;
  logic [15:0] mCnt;
  lockState_e mState;

  carrierLoop DUT (
    .clk(clk), .reset(reset), .symEn(symEn), .sym2xEn(sym2xEn), .phaseError(phaseError),
    .iqIn(iqIn), .bus(bus), .readData(readData), .iqOut(iqOut),
    .symEnDly(symEnDly), .sym2xEnDly(sym2xEnDly), .lockState(lockState)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Run stopped after %0d cycles without finishing the table", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // --------------------
  // Model
  task automatic modelWrite(input regAddr_e a, input logic [31:0] d, input logic [3:0] we);
    logic [31:0] m;
    m = {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
    case (a)
      ctrlReg: begin
        ctrlImg = ((ctrlImg & ~m) | (d & m)) & 32'h3;
        if (we[0] && d[2]) begin
          mLag = 0;
          mCnt = lockImg[15:0];
        end
      end
      gainReg:  gainImg = ((gainImg & ~m) | (d & m)) & 32'h1F1F;
      limitReg: limitImg = (limitImg & ~m) | (d & m);
      lockReg:  lockImg = ((lockImg & ~m) | (d & m)) & 32'hFFFFFF;
      default: ;
    endcase
  endtask

  function automatic logic [31:0] modelRead(input regAddr_e a);
    case (a)
      ctrlReg:     return ctrlImg;
      gainReg:     return gainImg;
      limitReg:    return limitImg;
      lockReg:     return lockImg;
      lagReadReg:  return mLag[39:8];
      freqReadReg: return mSum[39:8];
      statusReg:   return {31'd0, mState};
      default:     return 32'd0;
    endcase
  endfunction

  task automatic modelStrobe(input logic [7:0] e);
    logic signed [63:0] errExt, lagSum, lim;
    logic [7:0] mag;
    errExt = 64'($signed(mErr));
    lim = 64'(limitImg) << 8;
    lagSum = mLag + (errExt <<< gainImg[12:8]);
    mSum = mLag + (errExt <<< gainImg[4:0]);
    if (lagSum > lim) mLag = lim;
    else if (lagSum < -lim) mLag = -lim;
    else mLag = lagSum;
    mErr = ctrlImg[1] ? 8'd0 : (ctrlImg[0] ? 8'(-e) : e);
    // Lock counter wraps flip the state
    mag = e[7] ? 8'(-e) : e;
    if (mag > lockImg[23:16]) begin
      if (mCnt == 16'd0) begin
        mState = searching;
        mCnt = lockImg[15:0];
      end else mCnt = mCnt - 1;
    end else if (mCnt == 16'hFFFF) begin
      mState = locked;
      mCnt = lockImg[15:0];
    end else mCnt = mCnt + 1;
  endtask

  // --------------------
  // Table builders
  task automatic addWrite(input regAddr_e a, input logic [31:0] d, input logic [3:0] we);
    row_t r;
    r = '0;
    r.kind = rowWrite;
    r.bus = '{a, d, we};
    rows.push_back(r);
    modelWrite(a, d, we);
  endtask

  task automatic addRead(input regAddr_e a);
    row_t r;
    r = '0;
    r.kind = rowRead;
    r.bus.addr = a;
    r.expWord = modelRead(a);
    r.expLock = mState;
    rows.push_back(r);
  endtask

  task automatic addStrobe(input logic [7:0] e);
    row_t r;
    r = '0;
    r.kind = rowStrobe;
    r.err = e;
    rows.push_back(r);
    modelStrobe(e);
  endtask

  // At zero phase the NCO gives cos at table peak and sin zero
  task automatic addIq(input logic signed [17:0] i, input logic signed [17:0] q);
    row_t r;
    r = '0;
    r.kind = rowIq;
    r.iq = '{i, q};
    r.expIq.i = 18'((longint'(i) * 131071) >>> 17);
    r.expIq.q = 18'((longint'(q) * 131071) >>> 17);
    rows.push_back(r);
    modelStrobe(8'd0);
  endtask

  // --------------------
  // Compare tasks
  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic checkLock(input string name, input lockState_e got, input lockState_e exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic checkSample(input string name, input iqSample_t got, input iqSample_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got i=%h q=%h expected i=%h q=%h", name, got.i, got.q, exp.i, exp.q);
      mismatches++;
    end
  endtask

  // Each row starts 5 ns after a rising edge
  task automatic applyRow(input row_t r);
    case (r.kind)
      rowWrite: begin
        bus = r.bus;
        @(posedge clk) #5;
        bus.byteWe = '0;
        @(posedge clk) #5;
      end
      rowRead: begin
        bus.addr = r.bus.addr;
        #45;
        checkWord("readData", readData, r.expWord);
        if (r.bus.addr == statusReg) checkLock("lockState", lockState, r.expLock);
        @(posedge clk) #5;
      end
      default: begin
        symEn = 1'b1;
        sym2xEn = 1'b1;
        phaseError = r.err;
        iqIn = r.iq;
        @(posedge clk) #5;
        // Sample held for one clock only
        symEn = 1'b0;
        sym2xEn = 1'b0;
        iqIn = '0;
        repeat (3) @(posedge clk);
        #45;
        if (r.kind == rowIq) begin
          checkSample("iqOut", iqOut, r.expIq);
          if (symEnDly !== 1'b1) begin
            $display("symEnDly did not pulse four cycles after symEn");
            failures++;
          end
          if (sym2xEnDly !== 1'b1) begin
            $display("sym2xEnDly did not pulse four cycles after sym2xEn");
            failures++;
          end
        end
        repeat (2) @(posedge clk);
        #5;
      end
    endcase
  endtask

  initial begin
    logic [7:0] e;
    reset = 1'b1;
    symEn = 1'b0;
    sym2xEn = 1'b0;
    phaseError = '0;
    iqIn = '0;
    bus = '{ctrlReg, 32'd0, 4'd0};
    {ctrlImg, gainImg, limitImg, lockImg} = '0;
    {mErr, mLag, mSum, mCnt} = '0;
    mState = searching;

    // Derotation at zero frequency, NCO phase still zero
    addWrite(ctrlReg, 32'h6, 4'h1);
    addIq(18'sd1000, -18'sd5000);
    addIq(18'sd131071, -18'sd131072);
    addIq(-18'sd1, 18'sd77);
    repeat (3) addIq(18'(xorshift()), 18'(xorshift()));
    addRead(freqReadReg);

    // Byte lanes and read-only registers
    addWrite(limitReg, 32'h11223344, 4'hF);
    addWrite(limitReg, 32'hAABBCCDD, 4'b0101);
    addRead(limitReg);
    addWrite(gainReg, 32'hFFFFFFFF, 4'hF);
    addRead(gainReg);
    addWrite(lockReg, 32'h89ABCDEF, 4'b1010);
    addRead(lockReg);
    addWrite(ctrlReg, 32'h3, 4'h1);
    addRead(ctrlReg);
    addWrite(lagReadReg, 32'hFFFFFFFF, 4'hF);
    addWrite(statusReg, 32'hFFFFFFFF, 4'hF);
    addRead(lagReadReg);
    addRead(statusReg);

    // Loop filter in normal, inverted and zeroed modes
    addWrite(limitReg, 32'h7FFFFFFF, 4'hF);
    addWrite(gainReg, 32'h0C10, 4'hF);
    addWrite(ctrlReg, 32'h4, 4'h1);
    for (int n = 0; n < 18; n++) begin
      if (n == 8) addWrite(ctrlReg, 32'h1, 4'h1);
      if (n == 14) addWrite(ctrlReg, 32'h2, 4'h1);
      addStrobe(8'(xorshift()));
      addRead(lagReadReg);
      addRead(freqReadReg);
    end

    // Limit, then clear
    addWrite(ctrlReg, 32'h4, 4'h1);
    addWrite(limitReg, 32'h1000, 4'hF);
    addWrite(gainReg, 32'h0A00, 4'hF);
    repeat (12) begin
      addStrobe(8'd127);
      addRead(lagReadReg);
    end
    addWrite(ctrlReg, 32'h4, 4'h1);
    addRead(lagReadReg);

    // Lock up near the counter top, then drop with a short count
    addWrite(lockReg, {8'd0, 8'd20, 16'hFFFC}, 4'hF);
    addWrite(ctrlReg, 32'h4, 4'h1);
    for (int n = 0; n < 10 && mState != locked; n++) begin
      addStrobe(8'(xorshift() % 41) - 8'd20);
      addRead(statusReg);
    end
    addWrite(lockReg, {8'd0, 8'd20, 16'd3}, 4'hF);
    addWrite(ctrlReg, 32'h4, 4'h1);
    addRead(statusReg);
    for (int n = 0; n < 10 && mState != searching; n++) begin
      e = 8'd60 + 8'(xorshift() % 60);
      addStrobe(n[0] ? 8'(-e) : e);
      addRead(statusReg);
    end

    cycleLimit = rows.size() * 8 + 100;
    repeat (5) @(posedge clk);
    #5 reset = 1'b0;
    foreach (rows[n]) applyRow(rows[n]);
    failures += DUT.chk.assertFails;

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/carrierLoopPkg.sv
logic/loopRegs.sv
logic/loopFilter.sv
logic/lockDetector.sv
logic/carrierNco.sv
logic/derotator.sv
logic/carrierLoop.sv
tb/carrierLoop_checker.sv
tb/carrierLoopTb.sv

//--- Makefile
TOP = carrierLoopTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o Vsim

run: build
	./obj_dir/Vsim > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
